/* include/pma_settings.svh */
// sizes of the pma subsystem: register width, physical address width, entry count, index width
`ifndef PMA_SETTINGS_SVH
`define PMA_SETTINGS_SVH

////////////////////////////////////////
// core widths
////////////////////////////////////////

// register width, also the width of one address word in the table
`define XLEN 32
// physical address width after translation
`define PLEN 34

////////////////////////////////////////
// region table
////////////////////////////////////////

// number of region entries
`define PMA_CNT 8
// enough bits to address every entry
`define PMA_IDX_W 3

`endif

/* source/biu_pkg.sv */
// bus transfer types: transfer-size enum and access request struct
`include "pma_settings.svh"

package biu_pkg;

  ////////////////////////////////////////
  // transfer size
  ////////////////////////////////////////

  // bytes per transfer, no qword with a 32 bit core
  typedef enum logic [1:0] {
    BYTE  = 2'b00,
    HWORD = 2'b01,
    WORD  = 2'b10,
    DWORD = 2'b11
  } biu_size_t;

  ////////////////////////////////////////
  // access request
  ////////////////////////////////////////

  // one memory access as seen by the pma check
  typedef struct packed {
    logic [`PLEN-1:0] adr;        // physical byte address
    biu_size_t        size;       // transfer size
    logic             we;         // write access
    logic             instr;      // instruction fetch
    logic             misaligned; // flagged misaligned upstream
  } pma_access_t;

endpackage

/* source/pma_pkg.sv */
// pma types: memory-type and match-mode enums, entry config, region bounds, check result
`include "pma_settings.svh"

package pma_pkg;

  ////////////////////////////////////////
  // enums
  ////////////////////////////////////////

  // kind of memory behind a region
  typedef enum logic [1:0] {
    MEM_EMPTY = 2'b00,
    MEM_MAIN  = 2'b01,
    MEM_IO    = 2'b10
  } pma_mem_type_t;

  // address match mode, same encoding as pmp
  typedef enum logic [1:0] {
    OFF   = 2'b00,
    TOR   = 2'b01,
    NA4   = 2'b10,
    NAPOT = 2'b11
  } pma_amode_t;

  ////////////////////////////////////////
  // table entry
  ////////////////////////////////////////

  // attributes of one region
  typedef struct packed {
    pma_mem_type_t mem_type;
    logic          r;  // readable
    logic          w;  // writeable
    logic          x;  // executable
    logic          c;  // cacheable, main memory only
    logic          m;  // misaligned access allowed
    pma_amode_t    a;  // how the address word is decoded
  } pmacfg_t;

  // decoded region, word addresses
  typedef struct packed {
    logic [`PLEN-3:0] lb;  // first word inside
    logic [`PLEN-3:0] ub;  // first word past the end
  } pma_bounds_t;

  ////////////////////////////////////////
  // check result
  ////////////////////////////////////////

  // registered outputs of the checker
  typedef struct packed {
    logic exception;
    logic misaligned;
    logic cacheable;
  } pma_result_t;

endpackage

/* source/pma_cfg_regs.sv */
// pma region table: config and address words per entry, write strobes, normalization on write
`timescale 1ns/1ps
`include "pma_settings.svh"

module pma_cfg_regs
  import pma_pkg::*;
(
  input  logic                           clk_i,
  input  logic                           rst_i,
  input  logic                           cfg_we_i,
  input  logic                           adr_we_i,
  input  logic [`PMA_IDX_W-1:0]          cfg_idx_i,
  input  pmacfg_t                        cfg_data_i,
  input  logic [`XLEN-1:0]               adr_data_i,
  output pmacfg_t [`PMA_CNT-1:0]         cfg_o,
  output logic [`PMA_CNT-1:0][`XLEN-1:0] adr_o
);

  // entry state after reset, region disabled
  localparam pmacfg_t CFG_OFF = '{
    mem_type: MEM_EMPTY,
    r:        1'b0,
    w:        1'b0,
    x:        1'b0,
    c:        1'b0,
    m:        1'b0,
    a:        OFF
  };

  ////////////////////////////////////////
  // normalization
  ////////////////////////////////////////

  // turn a written config into legal attributes
  function automatic pmacfg_t normalize(pmacfg_t cfg);
    pmacfg_t res;
    res = cfg;
    // nothing behind an empty region, treat as io without access rights
    if (cfg.mem_type == MEM_EMPTY)
    begin
      res.mem_type = MEM_IO;
      res.r        = 1'b0;
      res.w        = 1'b0;
      res.x        = 1'b0;
    end
    // only main memory may be cached
    if (cfg.mem_type != MEM_MAIN)
      res.c = 1'b0;
    // m and a pass unchanged
    return res;
  endfunction

  ////////////////////////////////////////
  // table registers
  ////////////////////////////////////////

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      // every entry off, address words cleared
      for (int i = 0; i < `PMA_CNT; i++)
      begin
        cfg_o[i] <= CFG_OFF;
        adr_o[i] <= '0;
      end
    end
    else
    begin
      // both strobes may fire together
      if (cfg_we_i)
        cfg_o[cfg_idx_i] <= normalize(cfg_data_i);
      if (adr_we_i)
        adr_o[cfg_idx_i] <= adr_data_i;
    end
  end

endmodule

/* source/pma_region_bounds.sv */
// pma region bounds decoder: lower and upper word bound per entry from its match mode
`timescale 1ns/1ps
`include "pma_settings.svh"

module pma_region_bounds
  import pma_pkg::*;
(
  input  pmacfg_t [`PMA_CNT-1:0]         cfg_i,
  input  logic [`PMA_CNT-1:0][`XLEN-1:0] adr_i,
  output pma_bounds_t [`PMA_CNT-1:0]     bounds_o
);

  ////////////////////////////////////////
  // napot helpers
  ////////////////////////////////////////

  // low bits covered by a napot word
  // trailing ones plus the first zero, so 2^(n+1) words or 2^(n+3) bytes
  function automatic logic [`PLEN-3:0] napot_mask(logic [`PLEN-3:0] word);
    return word ^ (word + 1'b1);
  endfunction

  // region start, size aligned
  function automatic logic [`PLEN-3:0] napot_lb(logic [`PLEN-3:0] word);
    return word & ~napot_mask(word);
  endfunction

  // first word past the region
  function automatic logic [`PLEN-3:0] napot_ub(logic [`PLEN-3:0] word);
    return (word | napot_mask(word)) + 1'b1;
  endfunction

  ////////////////////////////////////////
  // bounds per entry
  ////////////////////////////////////////

  // state of the previous entry, tor builds on it
  pma_amode_t       prev_a;
  logic [`PLEN-3:0] prev_word;
  logic [`PLEN-3:0] prev_ub;

  // current entry
  logic [`PLEN-3:0] word;
  logic [`PLEN-3:0] ent_lb;
  logic [`PLEN-3:0] ent_ub;

  always_comb
  begin
    // entry 0 in tor mode starts at address zero
    prev_a    = TOR;
    prev_word = '0;
    prev_ub   = '0;
    for (int i = 0; i < `PMA_CNT; i++)
    begin
      // address word is already a word address
      word = adr_i[i][`PLEN-3:0];
      case (cfg_i[i].a)
        TOR:
        begin
          // previous tor word, otherwise end of the previous region
          ent_lb = (prev_a == TOR) ? prev_word : prev_ub;
          ent_ub = word;
        end
        NA4:
        begin
          ent_lb = word;
          ent_ub = word + 1'b1;
        end
        NAPOT:
        begin
          ent_lb = napot_lb(word);
          ent_ub = napot_ub(word);
        end
        default:
        begin
          // off, empty range
          ent_lb = '0;
          ent_ub = '0;
        end
      endcase
      bounds_o[i] = '{lb: ent_lb, ub: ent_ub};
      prev_a    = cfg_i[i].a;
      prev_word = word;
      prev_ub   = ent_ub;
    end
  end

endmodule

/* source/pma_checker.sv */
// pma checker: range match, priority select, registered exception, misaligned and cacheable
`timescale 1ns/1ps
`include "pma_settings.svh"

module pma_checker
  import biu_pkg::*;
  import pma_pkg::*;
(
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic                       stall_i,
  input  pma_access_t                access_i,
  input  pmacfg_t [`PMA_CNT-1:0]     cfg_i,
  input  pma_bounds_t [`PMA_CNT-1:0] bounds_i,
  output pma_result_t                result_o
);

  ////////////////////////////////////////
  // access range
  ////////////////////////////////////////

  // byte count of a transfer
  function automatic logic [3:0] size2bytes(biu_size_t size);
    case (size)
      BYTE:    return 4'd1;
      HWORD:   return 4'd2;
      WORD:    return 4'd4;
      default: return 4'd8;
    endcase
  endfunction

  logic [3:0]       nbytes;
  logic [`PLEN-1:0] acc_ub;
  logic [`PLEN-3:0] acc_lb_w;
  logic [`PLEN-3:0] acc_ub_w;

  // first and last byte of the access
  assign nbytes   = size2bytes(access_i.size);
  assign acc_ub   = access_i.adr + `PLEN'(nbytes) - `PLEN'(1);
  // compare on word granularity like the bounds
  assign acc_lb_w = access_i.adr[`PLEN-1:2];
  assign acc_ub_w = acc_ub[`PLEN-1:2];

  ////////////////////////////////////////
  // match and priority
  ////////////////////////////////////////

  logic [`PMA_CNT-1:0]   match_all;
  logic [`PMA_IDX_W-1:0] sel_idx;
  logic                  any_match;
  pmacfg_t               sel_cfg;

  // all bytes inside an enabled region
  for (genvar i = 0; i < `PMA_CNT; i++)
  begin : g_match
    assign match_all[i] = (cfg_i[i].a != OFF) &&
                          (acc_lb_w >= bounds_i[i].lb) &&
                          (acc_ub_w < bounds_i[i].ub);
  end

  // lowest index wins, scan from the top down
  always_comb
  begin
    sel_idx = '0;
    for (int i = `PMA_CNT-1; i >= 0; i--)
    begin
      if (match_all[i])
        sel_idx = `PMA_IDX_W'(i);
    end
  end

  assign any_match = |match_all;
  assign sel_cfg   = cfg_i[sel_idx];

  ////////////////////////////////////////
  // result
  ////////////////////////////////////////

  pma_result_t result_d;

  // no region, or a missing permission
  // fetches need x, writes need w, loads need r
  assign result_d.exception  = ~any_match |
                               (access_i.instr & ~sel_cfg.x) |
                               (access_i.we & ~sel_cfg.w) |
                               (~access_i.we & ~access_i.instr & ~sel_cfg.r);

  // misaligned passes unless the region allows it
  assign result_d.misaligned = access_i.misaligned & (~any_match | ~sel_cfg.m);

  // c is only ever set for main memory
  assign result_d.cacheable  = any_match & sel_cfg.c;

  // single register stage, held while stalled
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      result_o <= '0;
    else if (!stall_i)
      result_o <= result_d;
  end

endmodule

/* source/pma_unit_top.sv */
// pma unit top level: region table, bounds decoder and checker
`timescale 1ns/1ps
`include "pma_settings.svh"

module pma_unit_top
  import biu_pkg::*;
  import pma_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  stall_i,
  // table write port
  input  logic                  cfg_we_i,
  input  logic                  adr_we_i,
  input  logic [`PMA_IDX_W-1:0] cfg_idx_i,
  input  pmacfg_t               cfg_data_i,
  input  logic [`XLEN-1:0]      adr_data_i,
  // access under check
  input  pma_access_t           access_i,
  output pma_result_t           result_o
);

  pmacfg_t [`PMA_CNT-1:0]         cfg_w;
  logic [`PMA_CNT-1:0][`XLEN-1:0] adr_w;
  pma_bounds_t [`PMA_CNT-1:0]     bounds_w;

  // region table
  pma_cfg_regs u_cfg_regs (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .cfg_we_i   (cfg_we_i),
    .adr_we_i   (adr_we_i),
    .cfg_idx_i  (cfg_idx_i),
    .cfg_data_i (cfg_data_i),
    .adr_data_i (adr_data_i),
    .cfg_o      (cfg_w),
    .adr_o      (adr_w)
  );

  // bounds from match mode, combinational
  pma_region_bounds u_region_bounds (
    .cfg_i    (cfg_w),
    .adr_i    (adr_w),
    .bounds_o (bounds_w)
  );

  // registered check result
  pma_checker u_checker (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .stall_i  (stall_i),
    .access_i (access_i),
    .cfg_i    (cfg_w),
    .bounds_i (bounds_w),
    .result_o (result_o)
  );

endmodule

/* tb/pma_tb.sv */
// pma unit testbench: clock, reset, seeded random table and accesses, reference model, checks
`timescale 1ns/1ps
`include "pma_settings.svh"

module pma_tb
  import biu_pkg::*;
  import pma_pkg::*;
();

  localparam int    NUM_TESTS    = 6;
  localparam int    ACC_PER_TEST = 300;
  localparam longint TIMEOUT_NS  = (NUM_TESTS * ACC_PER_TEST + 100) * 40 * 2;

  logic                  clk_i;
  logic                  rst_i;
  logic                  stall_i;
  logic                  cfg_we_i;
  logic                  adr_we_i;
  logic [`PMA_IDX_W-1:0] cfg_idx_i;
  pmacfg_t               cfg_data_i;
  logic [`XLEN-1:0]      adr_data_i;
  pma_access_t           access_i;
  pma_result_t           result_o;

  pma_unit_top dut_i (.*);

  // model state: table copy and the result the register should hold
  pmacfg_t          m_cfg [`PMA_CNT];
  logic [`XLEN-1:0] m_adr [`PMA_CNT];
  pma_result_t      exp_q;
  int seed = 31841;
  int checks, errors, test_err;

  initial
  begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // watchdog, twice the longest expected run
  initial
  begin
    #(TIMEOUT_NS);
    $display("timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
    $display("sim failed");
    $finish;
  end

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////

  // legal attributes only: empty means io without rights, cache only for main
  function automatic pmacfg_t legal_cfg(pmacfg_t cfg);
    pmacfg_t res;
    logic    present;
    present      = (cfg.mem_type != MEM_EMPTY);
    res          = cfg;
    res.mem_type = present ? cfg.mem_type : MEM_IO;
    res.r        = cfg.r & present;
    res.w        = cfg.w & present;
    res.x        = cfg.x & present;
    res.c        = cfg.c & (cfg.mem_type == MEM_MAIN);
    return res;
  endfunction

  function automatic pma_result_t model_result(pma_access_t acc);
    pma_result_t res;
    longint      lb, ub, prev_w, prev_ub, size, first_w, last_w;
    pma_amode_t  prev_a;
    int          n, sel;
    first_w = acc.adr >> 2;
    last_w  = (longint'(acc.adr) + (64'd1 << acc.size) - 1) >> 2;
    prev_a  = TOR;
    prev_w  = 0;
    prev_ub = 0;
    sel     = -1;
    for (int i = 0; i < `PMA_CNT; i++)
    begin
      lb = 0;
      ub = 0;
      if (m_cfg[i].a == NA4)
      begin
        lb = m_adr[i];
        ub = lb + 1;
      end
      else if (m_cfg[i].a == NAPOT)
      begin
        // n trailing ones, 2^(n+1) words
        n = 0;
        while (n < `XLEN && m_adr[i][n])
          n++;
        size = 64'd1 << (n + 1);
        lb   = longint'(m_adr[i]) & ~(size - 1);
        ub   = lb + size;
      end
      else if (m_cfg[i].a == TOR)
      begin
        lb = (prev_a == TOR) ? prev_w : prev_ub;
        ub = m_adr[i];
      end
      // lowest index containing every byte
      if (sel < 0 && m_cfg[i].a != OFF && first_w >= lb && last_w < ub)
        sel = i;
      prev_a  = m_cfg[i].a;
      prev_w  = m_adr[i];
      prev_ub = ub;
    end
    if (sel < 0)
    begin
      res.exception  = 1'b1;
      res.misaligned = acc.misaligned;
      res.cacheable  = 1'b0;
    end
    else
    begin
      // each kind of access needs its own right
      if (acc.instr)
        res.exception = !m_cfg[sel].x;
      else if (acc.we)
        res.exception = !m_cfg[sel].w;
      else
        res.exception = !m_cfg[sel].r;
      res.misaligned = acc.misaligned && !m_cfg[sel].m;
      res.cacheable  = m_cfg[sel].c;
    end
    return res;
  endfunction

  ////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////

  task automatic compare_result(string name, pma_result_t exp, pma_result_t act);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("[FAIL] %s: expected exc/mis/cache %b actual %b", name, exp, act);
    end
  endtask

  task automatic compare_cfg(string name, int idx, pmacfg_t exp);
    pmacfg_t act;
    act = dut_i.u_cfg_regs.cfg_o[idx];
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("[FAIL] %s: expected cfg %h actual %h", name, exp, act);
    end
  endtask

  ////////////////////////////////////////
  // drivers and stimulus
  ////////////////////////////////////////

  // reset for 8 cycles, leaves time 5 ns after an edge
  task automatic apply_reset();
    rst_i   = 1'b1;
    stall_i = 1'b0;
    repeat (8) @(posedge clk_i);
    #5 rst_i = 1'b0;
    for (int i = 0; i < `PMA_CNT; i++)
    begin
      m_cfg[i] = '{mem_type: MEM_EMPTY, r: 0, w: 0, x: 0, c: 0, m: 0, a: OFF};
      m_adr[i] = '0;
    end
    exp_q = '0;
  endtask

  // stall holds the result during the write cycle
  task automatic write_entry(int idx, pmacfg_t cfg, logic [`XLEN-1:0] word);
    stall_i    = 1'b1;
    cfg_we_i   = 1'b1;
    adr_we_i   = 1'b1;
    cfg_idx_i  = `PMA_IDX_W'(idx);
    cfg_data_i = cfg;
    adr_data_i = word;
    @(posedge clk_i);
    #5;
    cfg_we_i   = 1'b0;
    adr_we_i   = 1'b0;
    m_cfg[idx] = legal_cfg(cfg);
    m_adr[idx] = word;
  endtask

  // result of this access shows right after the next edge
  task automatic check_access(string name, pma_access_t acc, logic stall);
    access_i = acc;
    stall_i  = stall;
    if (!stall)
      exp_q = model_result(acc);
    @(posedge clk_i);
    #5;
    compare_result(name, exp_q, result_o);
  endtask

  function automatic pmacfg_t random_cfg(pma_amode_t mode);
    pmacfg_t     cfg;
    logic [31:0] r;
    r            = $random(seed);
    cfg.mem_type = pma_mem_type_t'(r[1:0]);
    cfg.r        = r[2];
    cfg.w        = r[3];
    cfg.x        = r[4];
    cfg.c        = r[5];
    cfg.m        = r[6];
    cfg.a        = mode;
    return cfg;
  endfunction

  // words below 256, napot with up to 4 trailing ones
  function automatic logic [`XLEN-1:0] random_word(pma_amode_t mode);
    logic [`XLEN-1:0] w;
    int               k;
    w = $unsigned($random(seed)) % 256;
    if (mode == NAPOT)
    begin
      k = $unsigned($random(seed)) % 5;
      w = (w & ~((32'd1 << (k + 1)) - 1)) | ((32'd1 << k) - 1);
    end
    return w;
  endfunction

  function automatic pma_access_t random_access(int max_byte, logic force_mis);
    pma_access_t acc;
    logic [31:0] r;
    r         = $random(seed);
    acc.size  = biu_size_t'(r[1:0]);
    acc.we    = r[2];
    acc.instr = r[3] & ~r[2];
    acc.adr   = $unsigned($random(seed)) % max_byte;
    if (force_mis)
    begin
      if (acc.size == BYTE)
        acc.size = WORD;
      acc.adr[0] = 1'b1;
    end
    // flag set by address alignment to the transfer size
    acc.misaligned = (acc.adr & ((34'd1 << acc.size) - 1)) != 0;
    return acc;
  endfunction

  task automatic program_random_table();
    pma_amode_t mode;
    for (int i = 0; i < `PMA_CNT; i++)
    begin
      mode = pma_amode_t'(1 + $unsigned($random(seed)) % 3);
      write_entry(i, random_cfg(mode), random_word(mode));
    end
  endtask

  task automatic end_test(string name);
    $display("test %s done: %0d errors", name, errors - test_err);
    test_err = errors;
  endtask

  ////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////

  initial
  begin
    int          stall_left;
    pmacfg_t     ov_cfg;
    pma_access_t acc;
    rst_i = 1'b1;
    stall_i = 1'b0;
    cfg_we_i = 1'b0;
    adr_we_i = 1'b0;
    cfg_idx_i = '0;
    cfg_data_i = '0;
    adr_data_i = '0;
    access_i = '0;
    checks = 0;
    errors = 0;
    test_err = 0;

    // all entries off, nothing matches
    apply_reset();
    for (int n = 0; n < 40; n++)
      check_access("reset_all_off", random_access(1100, 1'b0), 1'b0);
    end_test("reset_all_off");

    apply_reset();
    program_random_table();
    for (int n = 0; n < ACC_PER_TEST; n++)
      check_access("random_regions", random_access(1100, 1'b0), 1'b0);
    end_test("random_regions");

    // empty with all rights, io with cache bit
    apply_reset();
    write_entry(0, '{mem_type: MEM_EMPTY, r: 1, w: 1, x: 1, c: 1, m: 1, a: NAPOT}, 32'h7);
    write_entry(1, '{mem_type: MEM_IO, r: 1, w: 1, x: 1, c: 1, m: 0, a: NA4}, 32'd20);
    compare_cfg("normalize_empty", 0, '{mem_type: MEM_IO, r: 0, w: 0, x: 0, c: 0, m: 1, a: NAPOT});
    compare_cfg("normalize_io", 1, '{mem_type: MEM_IO, r: 1, w: 1, x: 1, c: 0, m: 0, a: NA4});
    for (int n = 0; n < 50; n++)
      check_access("normalize", random_access(96, 1'b0), 1'b0);
    end_test("normalize");

    // na4 inside napot, tor from the napot end
    apply_reset();
    ov_cfg          = random_cfg(NA4);
    ov_cfg.mem_type = MEM_MAIN;
    write_entry(0, ov_cfg, 32'd8);
    // covering region with every attribute flipped
    ov_cfg.r = ~ov_cfg.r;
    ov_cfg.w = ~ov_cfg.w;
    ov_cfg.x = ~ov_cfg.x;
    ov_cfg.c = ~ov_cfg.c;
    ov_cfg.m = ~ov_cfg.m;
    ov_cfg.a = NAPOT;
    write_entry(1, ov_cfg, 32'hf);
    write_entry(2, random_cfg(TOR), 32'd64);
    for (int n = 0; n < 100; n++)
    begin
      acc = random_access(140, 1'b0);
      // every other access aimed at the na4 word, alignment kept
      if (n % 2 == 0)
        acc.adr = 34'd32 + acc.adr[1:0];
      check_access("overlap_priority", acc, 1'b0);
    end
    end_test("overlap_priority");

    apply_reset();
    program_random_table();
    for (int n = 0; n < 100; n++)
      check_access("misaligned", random_access(1100, 1'b1), 1'b0);
    end_test("misaligned");

    // random stall stretches of 1 to 6 cycles
    apply_reset();
    program_random_table();
    stall_left = 0;
    for (int n = 0; n < 200; n++)
    begin
      if (stall_left == 0 && ($unsigned($random(seed)) % 4) == 0)
        stall_left = 1 + $unsigned($random(seed)) % 6;
      check_access("stall_hold", random_access(1100, 1'b0), stall_left > 0);
      if (stall_left > 0)
        stall_left--;
    end
    end_test("stall_hold");

    $display("tests: %0d, checks: %0d, errors: %0d", NUM_TESTS, checks, errors);
    if (errors == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

endmodule

/* src.f */
+incdir+include
source/biu_pkg.sv
source/pma_pkg.sv
source/pma_cfg_regs.sv
source/pma_region_bounds.sv
source/pma_checker.sv
source/pma_unit_top.sv
tb/pma_tb.sv
